/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# pass only if the simulation prints the pass line
test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_idex -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_idex)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

/* src.f */
+incdir+tests
verilog/idex_pkg.sv
verilog/inst_decode.sv
verilog/int_alu.sv
verilog/next_pc_unit.sv
verilog/exec_commit.sv
verilog/idex_top.sv
tests/tb_idex.sv

/* tests/tb_idex_checks.svh */
`ifndef TB_IDEX_CHECKS_SVH
`define TB_IDEX_CHECKS_SVH

localparam logic [31:0] LFSR_TAPS = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1

// galois lfsr, one step per returned bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] val;
	val = '0;
	for (int i = 0; i < n; i++) begin
		val = {val[30:0], lfsr_state[0]};
		lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
	end
	return val;
endfunction

// RV32IM register result from funct3 and the sub/sra and M flags
function automatic logic [XLEN-1:0] model_alu(input logic [2:0] f3, input logic alt,
		input logic mext, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
	logic [63:0]     a_ext;
	logic [63:0]     b_ext;
	logic [63:0]     prod;
	logic [XLEN-1:0] sra;
	logic [XLEN-1:0] res;
	a_ext = (f3 == 3'd3) ? {32'b0, a} : {{32{a[31]}}, a};   // only mulhu takes a unsigned
	b_ext = (f3 == 3'd2 || f3 == 3'd3) ? {32'b0, b} : {{32{b[31]}}, b};
	prod  = a_ext * b_ext;
	sra   = $signed(a) >>> b[4:0];
	case (f3)
		3'd0:    res = alt ? a - b : a + b;
		3'd1:    res = a << b[4:0];
		3'd2:    res = {31'b0, $signed(a) < $signed(b)};
		3'd3:    res = {31'b0, a < b};
		3'd4:    res = a ^ b;
		3'd5:    res = alt ? sra : a >> b[4:0];
		3'd6:    res = a | b;
		default: res = a & b;
	endcase
	if (mext) begin
		res = (f3 == 3'd0) ? prod[31:0] : prod[63:32];
	end
	return res;
endfunction

function automatic logic model_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
	case (f3)
		3'd0:    return a == b;
		3'd1:    return a != b;
		3'd4:    return $signed(a) < $signed(b);
		3'd5:    return $signed(a) >= $signed(b);
		3'd6:    return a < b;
		default: return a >= b;
	endcase
endfunction

task automatic check_wdata(input string name, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
	checks = checks + 1;
	if (act !== exp) begin
		errors = errors + 1;
		$display("mismatch %s reg_wdata expected %h actual %h", name, exp, act);
	end
endtask

task automatic check_pc(input string name, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
	checks = checks + 1;
	if (act !== exp) begin
		errors = errors + 1;
		$display("mismatch %s pc_n expected %h actual %h", name, exp, act);
	end
endtask

// register index outputs, write and read side
task automatic check_addr(input string name, input string field,
		input logic [REG_ADDR_W-1:0] exp, input logic [REG_ADDR_W-1:0] act);
	checks = checks + 1;
	if (act !== exp) begin
		errors = errors + 1;
		$display("mismatch %s %s expected %0d actual %0d", name, field, exp, act);
	end
endtask

// flags as {valid, we, err}
task automatic check_flags(input string name, input logic [2:0] exp, input logic [2:0] act);
	checks = checks + 1;
	if (act !== exp) begin
		errors = errors + 1;
		$display("mismatch %s valid/we/err expected %b actual %b", name, exp, act);
	end
endtask

`endif

/* tests/tb_idex.sv */
`timescale 1ns/1ps

module tb_idex import idex_pkg::*; ();

	localparam int CLK_HALF   = 50;
	localparam int MAX_CYCLES = 2000;   // about 290 instructions at 2 cycles each
	localparam logic [31:0] LFSR_SEED  = 32'habf555db;
	localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
	localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;

	logic                  clk = 1'b0;
	logic                  rst_i;
	logic                  valid_i;
	logic [INST_W-1:0]     inst_i;
	logic [XLEN-1:0]       pc_i;
	logic [XLEN-1:0]       rs1_data_i;
	logic [XLEN-1:0]       rs2_data_i;
	logic [REG_ADDR_W-1:0] rs1_addr_o;
	logic [REG_ADDR_W-1:0] rs2_addr_o;
	logic                  valid_o;
	logic                  reg_we_o;
	logic [REG_ADDR_W-1:0] reg_waddr_o;
	logic [XLEN-1:0]       reg_wdata_o;
	logic [XLEN-1:0]       pc_n_o;
	logic                  inst_err_o;

	logic [31:0] lfsr_state;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_errs0 = 0;

	`include "tb_idex_checks.svh"

	idex_top idex_top_i (.*);

	always #(CLK_HALF) clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic start_test();
		test_errs0 = errors;
		tests_run  = tests_run + 1;
	endtask

	task automatic end_test(input string name);
		if (errors == test_errs0) begin
			$display("%s: ok", name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("%s: %0d errors", name, errors - test_errs0);
		end
	endtask

	// one instruction in, result checked one cycle later
	task automatic run_inst(input string name, input logic [INST_W-1:0] inst,
			input logic [XLEN-1:0] pc, input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
			input logic exp_we, input logic exp_err, input logic [XLEN-1:0] exp_wdata,
			input logic [XLEN-1:0] exp_pc);
		@(posedge clk);
		valid_i    <= 1'b1;
		inst_i     <= inst;
		pc_i       <= pc;
		rs1_data_i <= rs1;
		rs2_data_i <= rs2;
		@(negedge clk);   // read addresses follow the fields in the same cycle
		check_addr(name, "rs1_addr", inst[19:15], rs1_addr_o);
		check_addr(name, "rs2_addr", inst[24:20], rs2_addr_o);
		@(posedge clk);
		valid_i <= 1'b0;
		@(negedge clk);
		check_flags(name, {1'b1, exp_we, exp_err}, {valid_o, reg_we_o, inst_err_o});
		if (exp_we) begin
			check_wdata(name, exp_wdata, reg_wdata_o);
			check_addr(name, "reg_waddr", inst[11:7], reg_waddr_o);
		end
		check_pc(name, exp_pc, pc_n_o);
	endtask

	task automatic run_rr(input string name, input logic [2:0] f3, input logic [6:0] f7,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [XLEN-1:0] pc;
		logic [31:0]     inst;
		pc   = rand_bits(30) << 2;
		inst = enc_r(f7, 5'(rand_bits(5)), 5'(rand_bits(5)), f3, 5'(rand_bits(5)), OPC_OP);
		run_inst(name, inst, pc, a, b, 1'b1, 1'b0,
			model_alu(f3, f7 == F7_ALT, f7 == F7_MULDIV, a, b), pc + PC_STEP);
	endtask

	task automatic test_reset();
		start_test();
		check_flags("reset", 3'b000, {valid_o, reg_we_o, inst_err_o});
		check_wdata("reset", '0, reg_wdata_o);
		check_addr("reset", "reg_waddr", '0, reg_waddr_o);
		check_pc("reset", '0, pc_n_o);
		end_test("reset");
	endtask

	task automatic test_alu_random();
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] pc;
		logic [11:0]     imm12;
		logic            alt;
		start_test();
		for (int f3 = 0; f3 < 8; f3++) begin
			for (int rep = 0; rep < 4; rep++) begin
				alt = ((f3 == 0) || (f3 == 5)) && (rep % 2 == 1);
				run_rr("alu_random", 3'(f3), alt ? F7_ALT : F7_BASE, rand_bits(32), rand_bits(32));
				a     = rand_bits(32);
				pc    = rand_bits(30) << 2;
				imm12 = 12'(rand_bits(12));
				if (f3 == 1 || f3 == 5) begin
					imm12 = {alt ? F7_ALT : F7_BASE, imm12[4:0]};   // shamt form
				end
				run_inst("alu_random", enc_i(imm12, 5'(rand_bits(5)), 3'(f3), 5'(rand_bits(5)),
					OPC_OP_IMM), pc, a, '0, 1'b1, 1'b0,
					model_alu(3'(f3), alt && (f3 == 5), 1'b0, a, {{20{imm12[11]}}, imm12}),
					pc + PC_STEP);
			end
		end
		end_test("alu_random");
	endtask

	task automatic test_compare_mul();
		logic [XLEN-1:0] vals [5];
		start_test();
		vals = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin
				run_rr("compare_mul", 3'd2, F7_BASE, vals[i], vals[j]);
				run_rr("compare_mul", 3'd3, F7_BASE, vals[i], vals[j]);
				for (int f3 = 0; f3 < 4; f3++) begin
					run_rr("compare_mul", 3'(f3), F7_MULDIV, vals[i], vals[j]);
				end
			end
		end
		for (int rep = 0; rep < 4; rep++) begin
			for (int f3 = 0; f3 < 4; f3++) begin
				run_rr("compare_mul", 3'(f3), F7_MULDIV, rand_bits(32), rand_bits(32));
			end
		end
		end_test("compare_mul");
	endtask

	task automatic test_branches();
		logic [2:0]      conds [6];
		logic [XLEN-1:0] a_vals [5];
		logic [XLEN-1:0] b_vals [5];
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] exp_pc;
		logic [12:0]     imm13;
		start_test();
		conds  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		a_vals = '{rand_bits(32), 32'd1, 32'd2, 32'hffff_ffff, 32'd1};
		b_vals = '{a_vals[0], 32'd2, 32'd1, 32'd1, 32'hffff_ffff};   // equal, then both orders
		for (int c = 0; c < 6; c++) begin
			for (int p = 0; p < 5; p++) begin
				pc     = rand_bits(30) << 2;
				imm13  = 13'(rand_bits(12) << 1);
				exp_pc = model_taken(conds[c], a_vals[p], b_vals[p]) ?
					pc + {{19{imm13[12]}}, imm13} : pc + 32'd4;
				run_inst("branches", enc_b(imm13, 5'(rand_bits(5)), 5'(rand_bits(5)), conds[c]),
					pc, a_vals[p], b_vals[p], 1'b0, 1'b0, '0, exp_pc);
			end
		end
		end_test("branches");
	endtask

	task automatic test_jumps();
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] a;
		logic [20:0]     imm21;
		logic [11:0]     imm12;
		logic [19:0]     imm20;
		logic [4:0]      rd;
		start_test();
		for (int rep = 0; rep < 3; rep++) begin
			pc    = rand_bits(30) << 2;
			a     = rand_bits(32);
			rd    = 5'(rand_bits(5));
			imm21 = 21'(rand_bits(20) << 1);
			imm12 = 12'(rand_bits(12));
			imm20 = 20'(rand_bits(20));
			a[0]  = ~imm12[0];   // odd jalr sum, so bit 0 must be cleared
			run_inst("jumps", enc_j(imm21, rd), pc, a, '0, 1'b1, 1'b0, pc + 32'd4,
				pc + {{11{imm21[20]}}, imm21});
			run_inst("jumps", enc_i(imm12, 5'(rand_bits(5)), 3'b000, rd, OPC_JALR), pc, a, '0,
				1'b1, 1'b0, pc + 32'd4, (a + {{20{imm12[11]}}, imm12}) & ~32'h1);
			run_inst("jumps", {imm20, rd, OPC_LUI}, pc, a, '0, 1'b1, 1'b0, {imm20, 12'h000},
				pc + 32'd4);
			run_inst("jumps", {imm20, rd, OPC_AUIPC}, pc, a, '0, 1'b1, 1'b0,
				pc + {imm20, 12'h000}, pc + 32'd4);
		end
		end_test("jumps");
	endtask

	task automatic test_illegal();
		logic [XLEN-1:0] pc;
		logic [31:0]     inst;
		start_test();
		for (int k = 0; k < 4; k++) begin
			pc = rand_bits(30) << 2;
			case (k)
				0:       inst = enc_r(F7_MULDIV, 5'd2, 5'd1, 3'b100, 5'd3, OPC_OP);   // div
				1:       inst = enc_i(12'h010, 5'd1, 3'b010, 5'd3, OPC_LOAD);   // lw
				2:       inst = enc_i(12'h300, 5'd1, 3'b001, 5'd3, OPC_SYSTEM);   // csrrw
				default: inst = enc_r(7'b0010000, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP);
			endcase
			run_inst("illegal", inst, pc, rand_bits(32), rand_bits(32), 1'b0, 1'b1, '0, pc);
		end
		end_test("illegal");
	endtask

	task automatic test_stream();
		logic [XLEN-1:0] exp_wdata [10];
		logic [XLEN-1:0] exp_pc [10];
		logic [4:0]      exp_rd [10];
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] pc;
		logic [2:0]      f3;
		logic [6:0]      f7;
		start_test();
		for (int i = 0; i <= 10; i++) begin
			@(posedge clk);
			if (i < 10) begin
				a  = rand_bits(32);
				b  = rand_bits(32);
				pc = rand_bits(30) << 2;
				f3 = 3'(rand_bits(3));
				f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) == 32'd1) ? F7_ALT : F7_BASE;
				exp_rd[i]    = 5'(rand_bits(5));
				exp_wdata[i] = model_alu(f3, f7 == F7_ALT, 1'b0, a, b);
				exp_pc[i]    = pc + 32'd4;
				valid_i    <= 1'b1;
				inst_i     <= enc_r(f7, 5'd2, 5'd1, f3, exp_rd[i], OPC_OP);
				pc_i       <= pc;
				rs1_data_i <= a;
				rs2_data_i <= b;
			end else begin
				valid_i <= 1'b0;
			end
			@(negedge clk);
			if (i > 0) begin   // result of the previous input
				check_flags("stream", 3'b110, {valid_o, reg_we_o, inst_err_o});
				check_wdata("stream", exp_wdata[i-1], reg_wdata_o);
				check_addr("stream", "reg_waddr", exp_rd[i-1], reg_waddr_o);
				check_pc("stream", exp_pc[i-1], pc_n_o);
			end
		end
		@(posedge clk);
		@(negedge clk);
		check_flags("stream", 3'b000, {valid_o, reg_we_o, inst_err_o});
		end_test("stream");
	endtask

	initial begin
		rst_i      = 1'b1;
		valid_i    = 1'b0;
		inst_i     = '0;
		pc_i       = '0;
		rs1_data_i = '0;
		rs2_data_i = '0;
		lfsr_state = LFSR_SEED;
		repeat (2) @(posedge clk);
		rst_i <= 1'b0;
		@(negedge clk);
		test_reset();
		test_alu_random();
		test_compare_mul();
		test_branches();
		test_jumps();
		test_illegal();
		test_stream();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* verilog/exec_commit.sv */
`timescale 1ns/1ps

module exec_commit import idex_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  valid_i,
	input  logic                  wb_en_i,
	input  logic [REG_ADDR_W-1:0] rd_i,
	input  logic [XLEN-1:0]       alu_result_i,
	input  logic [XLEN-1:0]       pc_n_i,
	input  logic                  illegal_i,
	output logic                  valid_o,
	output logic                  reg_we_o,
	output logic [REG_ADDR_W-1:0] reg_waddr_o,
	output logic [XLEN-1:0]       reg_wdata_o,
	output logic [XLEN-1:0]       pc_n_o,
	output logic                  inst_err_o
);

	// strobes follow valid_i every cycle
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_o    <= 1'b0;
			reg_we_o   <= 1'b0;
			inst_err_o <= 1'b0;
		end else begin
			valid_o    <= valid_i;
			reg_we_o   <= valid_i & wb_en_i;
			inst_err_o <= valid_i & illegal_i;
		end
	end

	// result fields hold while idle
	always_ff @(posedge clk) begin
		if (rst_i) begin
			reg_waddr_o <= '0;
			reg_wdata_o <= '0;
			pc_n_o      <= '0;
		end else if (valid_i) begin
			reg_waddr_o <= rd_i;
			reg_wdata_o <= alu_result_i;
			pc_n_o      <= pc_n_i;
		end
	end

endmodule

/* verilog/idex_pkg.sv */
package idex_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int INST_W     = 32;

	localparam logic [XLEN-1:0] PC_STEP = 'd4;   // sequential pc increment

	// funct7 values that select the instruction variant
	localparam logic [6:0] F7_BASE   = 7'b0000000;
	localparam logic [6:0] F7_ALT    = 7'b0100000;   // sub and sra
	localparam logic [6:0] F7_MULDIV = 7'b0000001;   // M extension

	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_MUL,
		ALU_MULH,
		ALU_MULHSU,
		ALU_MULHU
	} alu_op_e;

	// same codes as the branch funct3 field
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} br_op_e;

	typedef enum logic [2:0] {
		PC_SEQ,      // pc + 4
		PC_BRANCH,   // conditional
		PC_JAL,      // pc + j imm
		PC_JALR,     // rs1 + i imm
		PC_HOLD      // stay on the faulting pc
	} pc_sel_e;

endpackage

/* verilog/idex_top.sv */
`timescale 1ns/1ps

module idex_top import idex_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  valid_i,
	input  logic [INST_W-1:0]     inst_i,
	input  logic [XLEN-1:0]       pc_i,
	input  logic [XLEN-1:0]       rs1_data_i,
	input  logic [XLEN-1:0]       rs2_data_i,
	output logic [REG_ADDR_W-1:0] rs1_addr_o,
	output logic [REG_ADDR_W-1:0] rs2_addr_o,
	output logic                  valid_o,
	output logic                  reg_we_o,
	output logic [REG_ADDR_W-1:0] reg_waddr_o,
	output logic [XLEN-1:0]       reg_wdata_o,
	output logic [XLEN-1:0]       pc_n_o,
	output logic                  inst_err_o
);

	logic [XLEN-1:0]       alu_a;
	logic [XLEN-1:0]       alu_b;
	alu_op_e               alu_op;
	logic [XLEN-1:0]       imm;
	br_op_e                br_op;
	pc_sel_e               pc_sel;
	logic                  wb_en;
	logic [REG_ADDR_W-1:0] rd;
	logic                  illegal;
	logic [XLEN-1:0]       alu_result;
	logic [XLEN-1:0]       pc_n;

	inst_decode inst_decode_i (
		.inst_i     (inst_i),
		.pc_i       (pc_i),
		.rs1_data_i (rs1_data_i),
		.rs2_data_i (rs2_data_i),
		.rs1_addr_o (rs1_addr_o),
		.rs2_addr_o (rs2_addr_o),
		.alu_a_o    (alu_a),
		.alu_b_o    (alu_b),
		.alu_op_o   (alu_op),
		.imm_o      (imm),
		.br_op_o    (br_op),
		.pc_sel_o   (pc_sel),
		.wb_en_o    (wb_en),
		.rd_o       (rd),
		.illegal_o  (illegal)
	);

	int_alu int_alu_i (
		.alu_a_i  (alu_a),
		.alu_b_i  (alu_b),
		.alu_op_i (alu_op),
		.result_o (alu_result)
	);

	next_pc_unit next_pc_unit_i (
		.pc_i       (pc_i),
		.rs1_data_i (rs1_data_i),
		.rs2_data_i (rs2_data_i),
		.imm_i      (imm),
		.br_op_i    (br_op),
		.pc_sel_i   (pc_sel),
		.pc_n_o     (pc_n)
	);

	exec_commit exec_commit_i (
		.clk          (clk),
		.rst_i        (rst_i),
		.valid_i      (valid_i),
		.wb_en_i      (wb_en),
		.rd_i         (rd),
		.alu_result_i (alu_result),
		.pc_n_i       (pc_n),
		.illegal_i    (illegal),
		.valid_o      (valid_o),
		.reg_we_o     (reg_we_o),
		.reg_waddr_o  (reg_waddr_o),
		.reg_wdata_o  (reg_wdata_o),
		.pc_n_o       (pc_n_o),
		.inst_err_o   (inst_err_o)
	);

endmodule

/* verilog/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode import idex_pkg::*; (
	input  logic [INST_W-1:0]     inst_i,
	input  logic [XLEN-1:0]       pc_i,
	input  logic [XLEN-1:0]       rs1_data_i,
	input  logic [XLEN-1:0]       rs2_data_i,
	output logic [REG_ADDR_W-1:0] rs1_addr_o,
	output logic [REG_ADDR_W-1:0] rs2_addr_o,
	output logic [XLEN-1:0]       alu_a_o,
	output logic [XLEN-1:0]       alu_b_o,
	output alu_op_e               alu_op_o,
	output logic [XLEN-1:0]       imm_o,
	output br_op_e                br_op_o,
	output pc_sel_e               pc_sel_o,
	output logic                  wb_en_o,
	output logic [REG_ADDR_W-1:0] rd_o,
	output logic                  illegal_o
);

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	logic            illegal;
	logic            wb_en;
	pc_sel_e         pc_sel;

	assign opcode = opcode_e'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign rs1_addr_o = inst_i[19:15];   // register file read, same cycle
	assign rs2_addr_o = inst_i[24:20];
	assign rd_o       = inst_i[11:7];

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'h000};
	assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	always_comb begin
		alu_a_o  = rs1_data_i;
		alu_b_o  = rs2_data_i;
		alu_op_o = ALU_ADD;
		imm_o    = imm_i;
		br_op_o  = BR_EQ;
		pc_sel   = PC_SEQ;
		wb_en    = 1'b1;
		illegal  = 1'b0;
		case (opcode)
			OPC_OP_IMM: begin
				alu_b_o = imm_i;
				case (funct3)
					3'b000: alu_op_o = ALU_ADD;
					3'b010: alu_op_o = ALU_SLT;
					3'b011: alu_op_o = ALU_SLTU;
					3'b100: alu_op_o = ALU_XOR;
					3'b110: alu_op_o = ALU_OR;
					3'b111: alu_op_o = ALU_AND;
					3'b001: begin
						alu_op_o = ALU_SLL;
						illegal  = (funct7 != F7_BASE);   // upper imm bits must be zero
					end
					default: begin   // srli / srai
						if (funct7 == F7_ALT) begin
							alu_op_o = ALU_SRA;
						end else begin
							alu_op_o = ALU_SRL;
						end
						illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
					end
				endcase
			end
			OPC_OP: begin
				if (funct7 == F7_MULDIV) begin
					case (funct3)
						3'b000:  alu_op_o = ALU_MUL;
						3'b001:  alu_op_o = ALU_MULH;
						3'b010:  alu_op_o = ALU_MULHSU;
						3'b011:  alu_op_o = ALU_MULHU;
						default: illegal  = 1'b1;   // no divider here
					endcase
				end else if (funct7 == F7_BASE) begin
					case (funct3)
						3'b000:  alu_op_o = ALU_ADD;
						3'b001:  alu_op_o = ALU_SLL;
						3'b010:  alu_op_o = ALU_SLT;
						3'b011:  alu_op_o = ALU_SLTU;
						3'b100:  alu_op_o = ALU_XOR;
						3'b101:  alu_op_o = ALU_SRL;
						3'b110:  alu_op_o = ALU_OR;
						default: alu_op_o = ALU_AND;
					endcase
				end else if (funct7 == F7_ALT) begin
					case (funct3)
						3'b000:  alu_op_o = ALU_SUB;
						3'b101:  alu_op_o = ALU_SRA;
						default: illegal  = 1'b1;
					endcase
				end else begin
					illegal = 1'b1;
				end
			end
			OPC_LUI: begin
				alu_a_o = '0;   // 0 + u imm
				alu_b_o = imm_u;
				imm_o   = imm_u;
			end
			OPC_AUIPC: begin
				alu_a_o = pc_i;
				alu_b_o = imm_u;
				imm_o   = imm_u;
			end
			OPC_JAL: begin
				alu_a_o = pc_i;   // link value pc + 4
				alu_b_o = PC_STEP;
				imm_o   = imm_j;
				pc_sel  = PC_JAL;
			end
			OPC_JALR: begin
				alu_a_o = pc_i;
				alu_b_o = PC_STEP;
				imm_o   = imm_i;
				pc_sel  = PC_JALR;
				illegal = (funct3 != 3'b000);
			end
			OPC_BRANCH: begin
				imm_o  = imm_b;
				pc_sel = PC_BRANCH;
				wb_en  = 1'b0;   // branches write no register
				case (funct3)
					3'b000:  br_op_o = BR_EQ;
					3'b001:  br_op_o = BR_NE;
					3'b100:  br_op_o = BR_LT;
					3'b101:  br_op_o = BR_GE;
					3'b110:  br_op_o = BR_LTU;
					3'b111:  br_op_o = BR_GEU;
					default: illegal = 1'b1;
				endcase
			end
			default: begin
				illegal = 1'b1;   // loads, stores, system, fence and the rest
			end
		endcase
	end

	assign illegal_o = illegal;
	assign wb_en_o   = wb_en & ~illegal;
	assign pc_sel_o  = illegal ? PC_HOLD : pc_sel;

endmodule

/* verilog/int_alu.sv */
`timescale 1ns/1ps

module int_alu import idex_pkg::*; (
	input  logic [XLEN-1:0] alu_a_i,
	input  logic [XLEN-1:0] alu_b_i,
	input  alu_op_e         alu_op_i,
	output logic [XLEN-1:0] result_o
);

	logic                      sub;
	logic [XLEN-1:0]           b_add;
	logic [XLEN-1:0]           sum;
	logic                      carry;
	logic                      lt_s;
	logic                      lt_u;
	logic [4:0]                shamt;
	logic [XLEN-1:0]           sll_res;
	logic [XLEN-1:0]           srl_res;
	logic [XLEN-1:0]           sra_res;
	logic                      a_signed;
	logic                      b_signed;
	logic signed [XLEN:0]      mul_a;
	logic signed [XLEN:0]      mul_b;
	logic signed [2*XLEN+1:0]  prod;

	// subtract for sub and both set-less-than ops
	assign sub   = (alu_op_i == ALU_SUB) || (alu_op_i == ALU_SLT) || (alu_op_i == ALU_SLTU);
	assign b_add = sub ? ~alu_b_i : alu_b_i;
	assign {carry, sum} = {1'b0, alu_a_i} + {1'b0, b_add} + {{XLEN{1'b0}}, sub};

	assign lt_u = ~carry;   // borrow out of a - b
	assign lt_s = (alu_a_i[XLEN-1] ^ alu_b_i[XLEN-1]) ? alu_a_i[XLEN-1] : sum[XLEN-1];

	assign shamt   = alu_b_i[4:0];
	assign sll_res = alu_a_i << shamt;
	assign srl_res = alu_a_i >> shamt;
	assign sra_res = $unsigned($signed(alu_a_i) >>> shamt);

	// operand signedness per multiply variant
	always_comb begin
		case (alu_op_i)
			ALU_MULHSU: begin
				a_signed = 1'b1;
				b_signed = 1'b0;
			end
			ALU_MULHU: begin
				a_signed = 1'b0;
				b_signed = 1'b0;
			end
			default: begin   // mul, mulh
				a_signed = 1'b1;
				b_signed = 1'b1;
			end
		endcase
	end

	assign mul_a = {a_signed & alu_a_i[XLEN-1], alu_a_i};
	assign mul_b = {b_signed & alu_b_i[XLEN-1], alu_b_i};
	assign prod  = mul_a * mul_b;   // 33 x 33 signed

	always_comb begin
		case (alu_op_i)
			ALU_ADD,
			ALU_SUB:    result_o = sum;
			ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_s};
			ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, lt_u};
			ALU_XOR:    result_o = alu_a_i ^ alu_b_i;
			ALU_OR:     result_o = alu_a_i | alu_b_i;
			ALU_AND:    result_o = alu_a_i & alu_b_i;
			ALU_SLL:    result_o = sll_res;
			ALU_SRL:    result_o = srl_res;
			ALU_SRA:    result_o = sra_res;
			ALU_MUL:    result_o = prod[XLEN-1:0];   // low word
			ALU_MULH,
			ALU_MULHSU,
			ALU_MULHU:  result_o = prod[2*XLEN-1:XLEN];   // high word
			default:    result_o = sum;
		endcase
	end

endmodule

/* verilog/next_pc_unit.sv */
`timescale 1ns/1ps

module next_pc_unit import idex_pkg::*; (
	input  logic [XLEN-1:0] pc_i,
	input  logic [XLEN-1:0] rs1_data_i,
	input  logic [XLEN-1:0] rs2_data_i,
	input  logic [XLEN-1:0] imm_i,
	input  br_op_e          br_op_i,
	input  pc_sel_e         pc_sel_i,
	output logic [XLEN-1:0] pc_n_o
);

	logic            eq;
	logic            lt_s;
	logic            lt_u;
	logic            taken;
	logic [XLEN-1:0] base;
	logic [XLEN-1:0] offset;
	logic [XLEN-1:0] target;

	assign eq   = (rs1_data_i == rs2_data_i);
	assign lt_s = ($signed(rs1_data_i) < $signed(rs2_data_i));
	assign lt_u = (rs1_data_i < rs2_data_i);

	always_comb begin
		case (br_op_i)
			BR_EQ:   taken = eq;
			BR_NE:   taken = ~eq;
			BR_LT:   taken = lt_s;
			BR_GE:   taken = ~lt_s;
			BR_LTU:  taken = lt_u;
			BR_GEU:  taken = ~lt_u;
			default: taken = 1'b0;
		endcase
	end

	// one target adder for every pc source
	assign base = (pc_sel_i == PC_JALR) ? rs1_data_i : pc_i;

	always_comb begin
		case (pc_sel_i)
			PC_BRANCH: offset = taken ? imm_i : PC_STEP;
			PC_JAL,
			PC_JALR:   offset = imm_i;
			default:   offset = PC_STEP;
		endcase
	end

	assign target = base + offset;

	always_comb begin
		case (pc_sel_i)
			PC_HOLD: pc_n_o = pc_i;   // illegal instruction
			PC_JALR: pc_n_o = {target[XLEN-1:1], 1'b0};   // lsb forced low
			default: pc_n_o = target;
		endcase
	end

endmodule
